//--- design/exu_defines.svh
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// data path and address width
`define REG_WIDTH 64

// raw instruction word
`define INST_WIDTH 32

// operand width of the RV64 word ops (addw, sllw, ...)
`define WORD_WIDTH 32

`endif

//--- design/exu_pkg.sv
`include "exu_defines.svh"

package exu_pkg;

    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_SLL    = 5'd2,
        ALU_SLT    = 5'd3,
        ALU_SLTU   = 5'd4,
        ALU_XOR    = 5'd5,
        ALU_SRL    = 5'd6,
        ALU_SRA    = 5'd7,
        ALU_OR     = 5'd8,
        ALU_AND    = 5'd9,
        // passes operand b through, used by lui
        ALU_COPY_B = 5'd10
    } alu_op_e;

    typedef enum logic {
        A_RS1 = 1'b0,
        A_PC  = 1'b1
    } alu_a_src_e;

    typedef enum logic [1:0] {
        B_RS2  = 2'd0,
        B_IMM  = 2'd1,
        B_FOUR = 2'd2
    } alu_b_src_e;

    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_JAL  = 4'd1,
        BR_JALR = 4'd2,
        BR_BEQ  = 4'd3,
        BR_BNE  = 4'd4,
        BR_BLT  = 4'd5,
        BR_BGE  = 4'd6,
        BR_BLTU = 4'd7,
        BR_BGEU = 4'd8
    } branch_e;

    // decoded instruction handed from decode to execute
    typedef struct packed {
        alu_a_src_e               alu_a_src;
        alu_b_src_e               alu_b_src;
        alu_op_e                  alu_op;
        logic                     word_op;
        logic                     sext_result;
        branch_e                  branch;
        logic [2:0]               mem_op;
        logic                     mem_wr;
        logic                     reg_wr;
        logic [1:0]               reg_src;
        logic                     is_ecall;
        logic                     is_mret;
        logic                     is_csr;
        logic [`REG_WIDTH-1:0]    rs1;
        logic [`REG_WIDTH-1:0]    rs2;
        logic [`REG_WIDTH-1:0]    imm;
        logic [`INST_WIDTH-1:0]   inst;
        logic [`REG_WIDTH-1:0]    pc;
    } id_exu_bundle_t;

    // execute result handed on to the memory stage
    typedef struct packed {
        logic [`REG_WIDTH-1:0]    alu_result;
        logic [`REG_WIDTH-1:0]    store_data;
        logic                     redirect;
        logic [`REG_WIDTH-1:0]    redirect_pc;
        logic [2:0]               mem_op;
        logic                     mem_wr;
        logic                     reg_wr;
        logic [1:0]               reg_src;
        logic                     is_ecall;
        logic                     is_mret;
        logic                     is_csr;
        logic [`INST_WIDTH-1:0]   inst;
        logic [`REG_WIDTH-1:0]    pc;
    } exu_mem_bundle_t;

endpackage

//--- design/id_exu_regs.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module id_exu_regs
    import exu_pkg::*;
(
    input  logic           clk,
    input  logic           i_arst_n,

    // from decode
    input  logic           i_valid,
    input  id_exu_bundle_t i_bundle,
    output logic           o_allow_in,

    // toward execute logic and the exit register
    input  logic           i_ready,
    output logic           o_valid,
    output id_exu_bundle_t o_bundle,

    // external squash of the entry slot
    input  logic           i_pipeline_flush
);

    logic           valid_q;
    logic           load;
    id_exu_bundle_t bundle_q;

    // free when empty or when the held instruction leaves this cycle
    assign o_allow_in = !valid_q || i_ready;

    // nothing is written while a flush is pending
    assign load = i_valid && o_allow_in && !i_pipeline_flush;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else if (i_pipeline_flush) begin
            valid_q <= 1'b0;
        end else if (o_allow_in) begin
            valid_q <= i_valid;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (load) begin
            bundle_q <= i_bundle;
        end
    end

    assign o_valid  = valid_q;
    assign o_bundle = bundle_q;

    // a stalled instruction must not change or vanish unless squashed
    a_hold_while_stalled: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (o_valid && !i_ready && !i_pipeline_flush) |=> (o_valid && $stable(o_bundle))
    ) else $error("id_exu_regs: stalled entry changed without flush");

endmodule

//--- design/exu_alu.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_alu
    import exu_pkg::*;
(
    input  id_exu_bundle_t        i_bundle,
    output logic [`REG_WIDTH-1:0] o_result
);

    localparam int SHAMT_W = $clog2(`REG_WIDTH);
    localparam int WORD_W  = `WORD_WIDTH;
    localparam int EXT_W   = `REG_WIDTH - `WORD_WIDTH;

    logic [`REG_WIDTH-1:0] op_a;
    logic [`REG_WIDTH-1:0] op_b;
    // operands after word-mode narrowing
    logic [`REG_WIDTH-1:0] a_sext;
    logic [`REG_WIDTH-1:0] a_zext;
    logic [`REG_WIDTH-1:0] b_sext;
    logic [SHAMT_W-1:0]    shamt;
    logic [`REG_WIDTH-1:0] raw;

    // operand a
    always_comb begin
        case (i_bundle.alu_a_src)
            A_PC:    op_a = i_bundle.pc;
            default: op_a = i_bundle.rs1;
        endcase
    end

    // operand b
    always_comb begin
        case (i_bundle.alu_b_src)
            B_IMM:   op_b = i_bundle.imm;
            B_FOUR:  op_b = `REG_WIDTH'(4);
            default: op_b = i_bundle.rs2;
        endcase
    end

    // word ops only look at the low half, shift amount drops to 5 bits
    always_comb begin
        if (i_bundle.word_op) begin
            a_sext = {{EXT_W{op_a[WORD_W-1]}}, op_a[WORD_W-1:0]};
            a_zext = {{EXT_W{1'b0}}, op_a[WORD_W-1:0]};
            b_sext = {{EXT_W{op_b[WORD_W-1]}}, op_b[WORD_W-1:0]};
            shamt  = {1'b0, op_b[SHAMT_W-2:0]};
        end else begin
            a_sext = op_a;
            a_zext = op_a;
            b_sext = op_b;
            shamt  = op_b[SHAMT_W-1:0];
        end
    end

    always_comb begin
        case (i_bundle.alu_op)
            ALU_ADD:    raw = a_sext + b_sext;
            ALU_SUB:    raw = a_sext - b_sext;
            ALU_SLL:    raw = op_a << shamt;
            ALU_SLT:    raw = `REG_WIDTH'($signed(a_sext) < $signed(b_sext));
            ALU_SLTU:   raw = `REG_WIDTH'(a_sext < b_sext);
            ALU_XOR:    raw = a_sext ^ b_sext;
            // srl must shift in zeros above a word operand
            ALU_SRL:    raw = a_zext >> shamt;
            ALU_SRA:    raw = $signed(a_sext) >>> shamt;
            ALU_OR:     raw = a_sext | b_sext;
            ALU_AND:    raw = a_sext & b_sext;
            ALU_COPY_B: raw = op_b;
            default:    raw = '0;
        endcase
    end

    // addw/subw/... results are sign-extended from bit 31
    always_comb begin
        if (i_bundle.sext_result) begin
            o_result = {{EXT_W{raw[WORD_W-1]}}, raw[WORD_W-1:0]};
        end else begin
            o_result = raw;
        end
    end

endmodule

//--- design/exu_branch.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_branch
    import exu_pkg::*;
(
    input  id_exu_bundle_t        i_bundle,
    output logic                  o_redirect,
    output logic [`REG_WIDTH-1:0] o_redirect_pc
);

    logic                  is_eq;
    logic                  is_lt;
    logic                  is_ltu;
    logic [`REG_WIDTH-1:0] pc_target;
    logic [`REG_WIDTH-1:0] reg_target;

    // compare rs1 against rs2
    assign is_eq  = (i_bundle.rs1 == i_bundle.rs2);
    assign is_lt  = ($signed(i_bundle.rs1) < $signed(i_bundle.rs2));
    assign is_ltu = (i_bundle.rs1 < i_bundle.rs2);

    // take or not
    always_comb begin
        case (i_bundle.branch)
            BR_JAL,
            BR_JALR: o_redirect = 1'b1;
            BR_BEQ:  o_redirect = is_eq;
            BR_BNE:  o_redirect = !is_eq;
            BR_BLT:  o_redirect = is_lt;
            BR_BGE:  o_redirect = !is_lt;
            BR_BLTU: o_redirect = is_ltu;
            BR_BGEU: o_redirect = !is_ltu;
            default: o_redirect = 1'b0;
        endcase
    end

    assign pc_target = i_bundle.pc + i_bundle.imm;

    // jalr clears bit 0 of the sum
    assign reg_target = (i_bundle.rs1 + i_bundle.imm) & ~`REG_WIDTH'(1);

    always_comb begin
        if (i_bundle.branch == BR_JALR) begin
            o_redirect_pc = reg_target;
        end else begin
            o_redirect_pc = pc_target;
        end
    end

endmodule

//--- design/exu_mem_regs.sv
`timescale 1ns/1ps

module exu_mem_regs
    import exu_pkg::*;
(
    input  logic            clk,
    input  logic            i_arst_n,

    // from execute logic
    input  logic            i_valid,
    input  exu_mem_bundle_t i_bundle,
    output logic            o_allow_in,

    // toward the memory stage
    input  logic            i_ready,
    output logic            o_valid,
    output exu_mem_bundle_t o_bundle
);

    logic            valid_q;
    logic            load;
    exu_mem_bundle_t bundle_q;

    assign o_allow_in = !valid_q || i_ready;
    assign load       = i_valid && o_allow_in;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else if (o_allow_in) begin
            valid_q <= i_valid;
        end
    end

    // result payload, written on accept only
    always_ff @(posedge clk) begin
        if (load) begin
            bundle_q <= i_bundle;
        end
    end

    assign o_valid  = valid_q;
    assign o_bundle = bundle_q;

    // a result offered to memory is not withdrawn before it is taken
    a_valid_held: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (o_valid && !i_ready) |=> o_valid
    ) else $error("exu_mem_regs: o_valid dropped without a transfer");

    // and its contents stay put while it waits
    a_payload_held: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (o_valid && !i_ready) |=> $stable(o_bundle)
    ) else $error("exu_mem_regs: result changed while stalled");

endmodule

//--- design/exu_stage.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_stage
    import exu_pkg::*;
(
    input  logic            clk,
    input  logic            i_arst_n,

    input  logic            i_id_valid,
    input  id_exu_bundle_t  i_id_bundle,
    output logic            o_exu_allow_in,

    input  logic            i_mem_ready,
    output logic            o_mem_valid,
    output exu_mem_bundle_t o_mem_bundle,

    input  logic            i_pipeline_flush
);

    logic                  exu_valid;
    id_exu_bundle_t        exu_bundle;
    logic                  mem_allow_in;
    logic [`REG_WIDTH-1:0] alu_result;
    logic                  redirect;
    logic [`REG_WIDTH-1:0] redirect_pc;
    exu_mem_bundle_t       result;

    id_exu_regs id_exu_regs_inst (
        .clk              (clk),
        .i_arst_n         (i_arst_n),
        .i_valid          (i_id_valid),
        .i_bundle         (i_id_bundle),
        .o_allow_in       (o_exu_allow_in),
        .i_ready          (mem_allow_in),
        .o_valid          (exu_valid),
        .o_bundle         (exu_bundle),
        .i_pipeline_flush (i_pipeline_flush)
    );

    exu_alu exu_alu_inst (
        .i_bundle (exu_bundle),
        .o_result (alu_result)
    );

    exu_branch exu_branch_inst (
        .i_bundle      (exu_bundle),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc)
    );

    // control fields ride along into the result untouched
    always_comb begin
        result.alu_result  = alu_result;
        result.store_data  = exu_bundle.rs2;
        result.redirect    = redirect;
        result.redirect_pc = redirect_pc;
        result.mem_op      = exu_bundle.mem_op;
        result.mem_wr      = exu_bundle.mem_wr;
        result.reg_wr      = exu_bundle.reg_wr;
        result.reg_src     = exu_bundle.reg_src;
        result.is_ecall    = exu_bundle.is_ecall;
        result.is_mret     = exu_bundle.is_mret;
        result.is_csr      = exu_bundle.is_csr;
        result.inst        = exu_bundle.inst;
        result.pc          = exu_bundle.pc;
    end

    // a flushed instruction in execute must not move on into the exit register
    exu_mem_regs exu_mem_regs_inst (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_valid    (exu_valid && !i_pipeline_flush),
        .i_bundle   (result),
        .o_allow_in (mem_allow_in),
        .i_ready    (i_mem_ready),
        .o_valid    (o_mem_valid),
        .o_bundle   (o_mem_bundle)
    );

endmodule

//--- testbench/tb_exu_stage.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module tb_exu_stage
    import exu_pkg::*;
();

    localparam int NUM_LINES  = 31;
    localparam int FIELDS     = 9;
    localparam int RESET_CYC  = 5;
    localparam int MAX_CYCLES = NUM_LINES * 40 + RESET_CYC;

    logic            clk;
    logic            i_arst_n;
    logic            i_id_valid;
    id_exu_bundle_t  i_id_bundle;
    logic            o_exu_allow_in;
    logic            i_mem_ready;
    logic            o_mem_valid;
    exu_mem_bundle_t o_mem_bundle;
    logic            i_pipeline_flush;

    logic [`REG_WIDTH-1:0] stim_mem [0:NUM_LINES*FIELDS-1];
    integer seed;
    int     cycle_count;
    int     error_count;
    int     check_count;
    int     sent_count;
    int     recv_count;
    int     chk_ptr;
    int     expected_results;
    logic   id_accepted;
    logic   hold_ready;

    exu_stage exu_stage_inst (
        .clk              (clk),
        .i_arst_n         (i_arst_n),
        .i_id_valid       (i_id_valid),
        .i_id_bundle      (i_id_bundle),
        .o_exu_allow_in   (o_exu_allow_in),
        .i_mem_ready      (i_mem_ready),
        .o_mem_valid      (o_mem_valid),
        .o_mem_bundle     (o_mem_bundle),
        .i_pipeline_flush (i_pipeline_flush)
    );

    always #5 clk = ~clk;

    function automatic logic [3:0] flush_mode(input int idx);
        return stim_mem[idx*FIELDS][55:52];
    endfunction

    // one hex digit per control field, see the file's first line
    function automatic id_exu_bundle_t build_bundle(input int idx);
        id_exu_bundle_t b;
        logic [`REG_WIDTH-1:0] c;
        c             = stim_mem[idx*FIELDS];
        b.alu_a_src   = alu_a_src_e'(c[48]);
        b.alu_b_src   = alu_b_src_e'(c[45:44]);
        b.alu_op      = alu_op_e'({1'b0, c[43:40]});
        b.word_op     = c[36];
        b.sext_result = c[32];
        b.branch      = branch_e'(c[31:28]);
        b.mem_op      = c[26:24];
        b.mem_wr      = c[20];
        b.reg_wr      = c[16];
        b.reg_src     = c[13:12];
        b.is_ecall    = c[8];
        b.is_mret     = c[4];
        b.is_csr      = c[0];
        b.rs1         = stim_mem[idx*FIELDS+1];
        b.rs2         = stim_mem[idx*FIELDS+2];
        b.imm         = stim_mem[idx*FIELDS+3];
        b.inst        = stim_mem[idx*FIELDS+4][`INST_WIDTH-1:0];
        b.pc          = stim_mem[idx*FIELDS+5];
        return b;
    endfunction

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
        check_count++;
        if (got !== expected) begin
            $display("[ERROR] %s at pc %h: got %h, expected %h",
                     name, o_mem_bundle.pc, got, expected);
            error_count++;
        end
    endtask

    task automatic check_result(input int idx);
        id_exu_bundle_t exp_in;
        int base;
        exp_in = build_bundle(idx);
        base   = idx * FIELDS;
        compare_field("pc", o_mem_bundle.pc, exp_in.pc);
        compare_field("inst", o_mem_bundle.inst, exp_in.inst);
        compare_field("alu_result", o_mem_bundle.alu_result, stim_mem[base+6]);
        compare_field("redirect", o_mem_bundle.redirect, stim_mem[base+7]);
        // target only means something when taken
        if (stim_mem[base+7][0]) begin
            compare_field("redirect_pc", o_mem_bundle.redirect_pc, stim_mem[base+8]);
        end
        compare_field("store_data", o_mem_bundle.store_data, exp_in.rs2);
        compare_field("mem_op", o_mem_bundle.mem_op, exp_in.mem_op);
        compare_field("mem_wr", o_mem_bundle.mem_wr, exp_in.mem_wr);
        compare_field("reg_wr", o_mem_bundle.reg_wr, exp_in.reg_wr);
        compare_field("reg_src", o_mem_bundle.reg_src, exp_in.reg_src);
        compare_field("is_ecall", o_mem_bundle.is_ecall, exp_in.is_ecall);
        compare_field("is_mret", o_mem_bundle.is_mret, exp_in.is_mret);
        compare_field("is_csr", o_mem_bundle.is_csr, exp_in.is_csr);
    endtask

    // new inputs go out 1 ns after the edge, ready about 70 % high
    task automatic step_cycle();
        @(posedge clk);
        #1;
        if (hold_ready) begin
            i_mem_ready = 1'b0;
        end else begin
            i_mem_ready = ({$random(seed)} % 10) < 7;
        end
    endtask

    task automatic offer_line(input int idx);
        i_id_bundle = build_bundle(idx);
        i_id_valid  = 1'b1;
        do begin
            step_cycle();
        end while (!id_accepted);
        i_id_valid = 1'b0;
        sent_count++;
    endtask

    task automatic flush_line(input int idx);
        // drain whatever is still in flight
        while (recv_count < sent_count) begin
            step_cycle();
        end
        i_id_bundle = build_bundle(idx);
        i_id_valid  = 1'b1;
        if (flush_mode(idx) == 4'd1) begin
            i_pipeline_flush = 1'b1;
            step_cycle();
        end else begin
            // park it in the entry register with memory stalled, then squash
            hold_ready  = 1'b1;
            i_mem_ready = 1'b0;
            do begin
                step_cycle();
            end while (!id_accepted);
            i_id_valid       = 1'b0;
            i_pipeline_flush = 1'b1;
            step_cycle();
            hold_ready = 1'b0;
        end
        i_id_valid       = 1'b0;
        i_pipeline_flush = 1'b0;
    endtask

    // handshakes are sampled mid-cycle, the transfers happen at the next edge
    always @(negedge clk) begin
        if (!i_arst_n) begin
            id_accepted = 1'b0;
        end else begin
            id_accepted = i_id_valid && o_exu_allow_in && !i_pipeline_flush;
            if (o_mem_valid && i_mem_ready) begin
                while (chk_ptr < NUM_LINES && flush_mode(chk_ptr) != 4'd0) begin
                    chk_ptr++;
                end
                if (chk_ptr >= NUM_LINES) begin
                    $display("unexpected result with pc %h after the last line", o_mem_bundle.pc);
                    error_count++;
                end else begin
                    check_result(chk_ptr);
                    chk_ptr++;
                end
                recv_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles with %0d of %0d results received",
                     cycle_count, recv_count, expected_results);
            $display("checks: %0d, errors: %0d", check_count, error_count + 1);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        int line_idx;
        clk              = 1'b0;
        i_arst_n         = 1'b0;
        i_id_valid       = 1'b0;
        i_id_bundle      = '0;
        i_mem_ready      = 1'b0;
        i_pipeline_flush = 1'b0;
        hold_ready       = 1'b0;
        id_accepted      = 1'b0;
        seed             = 1;
        cycle_count      = 0;
        error_count      = 0;
        check_count      = 0;
        sent_count       = 0;
        recv_count       = 0;
        chk_ptr          = 0;
        expected_results = 0;

        $readmemh("testbench/exu_stimulus.mem", stim_mem);
        if ($isunknown(stim_mem[NUM_LINES*FIELDS-1])) begin
            $display("stimulus file is missing or has fewer than %0d lines", NUM_LINES);
            error_count++;
        end
        for (line_idx = 0; line_idx < NUM_LINES; line_idx++) begin
            if (flush_mode(line_idx) == 4'd0) begin
                expected_results++;
            end
        end

        repeat (RESET_CYC) @(posedge clk);
        #1;
        i_arst_n = 1'b1;
        check_count += 2;
        if (o_mem_valid !== 1'b0) begin
            $display("[ERROR] o_mem_valid after reset: got %h, expected 0", o_mem_valid);
            error_count++;
        end
        if (o_exu_allow_in !== 1'b1) begin
            $display("[ERROR] o_exu_allow_in after reset: got %h, expected 1", o_exu_allow_in);
            error_count++;
        end

        for (line_idx = 0; line_idx < NUM_LINES; line_idx++) begin
            if (flush_mode(line_idx) == 4'd0) begin
                offer_line(line_idx);
            end else begin
                flush_line(line_idx);
            end
        end
        while (recv_count < sent_count) begin
            step_cycle();
        end
        // a squashed instruction showing up late would be caught here
        repeat (4) step_cycle();
        if (recv_count != expected_results) begin
            $display("expected %0d results but received %0d", expected_results, recv_count);
            error_count++;
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+design
design/exu_pkg.sv
design/id_exu_regs.sv
design/exu_alu.sv
design/exu_branch.sv
design/exu_mem_regs.sv
design/exu_stage.sv
testbench/tb_exu_stage.sv

//--- Bender.yml
package:
  name: exu_stage

sources:
  - include_dirs:
      - design
    files:
      - design/exu_pkg.sv
      - design/id_exu_regs.sv
      - design/exu_alu.sv
      - design/exu_branch.sv
      - design/exu_mem_regs.sv
      - design/exu_stage.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_exu_stage.sv

//--- testbench/exu_stimulus.mem
// ctrl digits: flush a_src b_src alu_op _ word sext branch _ mem_op mem_wr reg_wr reg_src _ ecall mret csr
// then: rs1 rs2 imm inst pc exp_alu_result exp_redirect exp_redirect_pc (flush 1 same cycle, 2 held)
0000_000_0010_000 5 7 0 00700333 1000 c 0 0
0001_000_0010_000 3 5 0 40b50533 1004 fffffffffffffffe 0 0
0002_000_0010_000 81 44 0 00b51533 1008 810 0 0
0003_000_0010_000 ffffffffffffffff 1 0 00b52533 100c 1 0 0
0004_000_0010_000 ffffffffffffffff 1 0 00b53533 1010 0 0 0
0015_000_0010_000 ff00 0 f0f 0f0fc513 1014 f00f 0 0
0006_000_0010_000 8000000000000000 3f 0 00b55533 1018 1 0 0
0007_000_0010_000 8000000000000000 4 0 40b55533 101c f800000000000000 0 0
0008_000_0010_000 f0 f 0 00b56533 1020 ff 0 0
0019_000_0010_000 ff 0 fffffffffffffff0 ff057513 1024 f0 0 0
001a_000_0010_000 0 0 ffffffff80000000 80000537 1028 ffffffff80000000 0 0
0110_000_0010_000 0 0 2000 00002517 102c 302c 0 0
0000_110_0010_000 7fffffff 1 0 00b5053b 1030 ffffffff80000000 0 0
0001_110_0010_000 100000000 1 0 40b5053b 1034 ffffffffffffffff 0 0
0002_110_0010_000 1 21 0 00b5153b 1038 2 0 0
0006_110_0010_000 ffffffff80000000 4 0 00b5553b 103c 8000000 0 0
0007_110_0010_000 80000000 4 0 40b5553b 1040 fffffffff8000000 0 0
0010_000_3100_000 2000 deadbeefcafef00d 8 00a53423 1044 2008 0 0
1000_000_0010_000 1 1 0 00000013 1048 0 0 0
0120_001_0012_000 0 0 100 100000ef 104c 1050 1 114c
0120_002_0012_000 2001 0 10 010080e7 1050 1054 1 2010
2000_000_0010_000 2 2 0 00000013 1054 0 0 0
0001_003_0000_000 5 5 fffffffffffffff0 fe0508e3 1058 0 1 1048
0001_004_0000_000 5 5 20 02051063 105c 0 0 0
0001_005_0000_000 ffffffffffffffff 1 40 04054063 1060 fffffffffffffffe 1 10a0
0001_006_0000_000 ffffffffffffffff 1 40 04055063 1064 fffffffffffffffe 0 0
0001_007_0000_000 ffffffffffffffff 1 40 04056063 1068 fffffffffffffffe 0 0
0001_008_0000_000 ffffffffffffffff 1 8 00057463 106c fffffffffffffffe 1 1074
0000_000_0000_100 0 0 0 00000073 1070 0 0 0
0000_000_0013_001 abc 0 0 34051073 1074 abc 0 0
0000_000_0000_010 0 0 0 30200073 1078 0 0 0
